/* design/video_pkg.sv */
package video_pkg;

  // one channel of the 4:4:4 pixel
  localparam int CHAN_W = 4;

  // pixel word is {r, g, b} with red in the top nibble
  typedef logic [3*CHAN_W-1:0] rgb_t;

  // raster coordinates, sized for 640x480 at most
  typedef logic [9:0] coord_x_t;
  typedef logic [8:0] coord_y_t;

  // sprite is square
  localparam int SPRITE_SIZE = 8;

  // row and column index width inside the sprite
  localparam int SPRITE_AW = $clog2(SPRITE_SIZE);

  // bit 0 is the leftmost pixel of the row
  typedef logic [SPRITE_SIZE-1:0] mask_row_t;

endpackage

/* design/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 16
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t wr_data,
  input  logic     pop,
  output payload_t rd_data,
  output logic     full,
  output logic     empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  // ops against a full/empty buffer are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full    = (count == CW'(DEPTH));
  assign empty   = (count == '0);
  assign rd_data = mem[rd_ptr];   // show-ahead head

  // wrap without needing a power-of-two depth
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;     // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wr_data;
  end

  a_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
    else $warning("sync_fifo: push while full, data dropped");

  a_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
    else $warning("sync_fifo: pop while empty, ignored");

endmodule

/* design/pixel_counter.sv */
`timescale 1ns/1ps

module pixel_counter #(
  parameter int H_ACTIVE = 640,
  parameter int V_ACTIVE = 480
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               pc_enable,
  output video_pkg::coord_x_t pixel_x,
  output video_pkg::coord_y_t pixel_y,
  output logic               last_pixel,
  output logic               new_frame
);

  import video_pkg::*;

  localparam coord_x_t X_LAST = coord_x_t'(H_ACTIVE - 1);
  localparam coord_y_t Y_LAST = coord_y_t'(V_ACTIVE - 1);

  logic end_of_line;

  assign end_of_line = (pixel_x == X_LAST);
  assign last_pixel  = end_of_line && (pixel_y == Y_LAST);   // sole frame-end decision

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pixel_x   <= '0;
      pixel_y   <= '0;
      new_frame <= 1'b0;
    end else begin
      new_frame <= pc_enable && last_pixel;   // lands with the (0,0) wrap
      if (pc_enable) begin
        if (end_of_line) begin
          pixel_x <= '0;
          pixel_y <= (pixel_y == Y_LAST) ? '0 : pixel_y + 1'b1;
        end else begin
          pixel_x <= pixel_x + 1'b1;
        end
      end
    end
  end

  a_x_range: assert property (@(posedge clk) disable iff (!rst_n)
    pixel_x < coord_x_t'(H_ACTIVE))
    else $error("pixel_counter: pixel_x out of the active line");

endmodule

/* design/sprite_fetcher.sv */
`timescale 1ns/1ps

module sprite_fetcher (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               frame_start,
  input  logic                               sprite_en_in,
  input  video_pkg::coord_x_t                sprite_x_in,
  input  video_pkg::coord_y_t                sprite_y_in,
  input  video_pkg::rgb_t                    sprite_color_in,
  input  logic                               mask_we,
  input  logic [video_pkg::SPRITE_AW-1:0]    mask_row,
  input  video_pkg::mask_row_t               mask_data,
  input  logic                               start_fetch,
  input  video_pkg::coord_x_t                pixel_x,
  input  video_pkg::coord_y_t                pixel_y,
  output logic                               sprites_ready,
  output logic                               fetch_done,
  output logic                               sprite_hit,
  output video_pkg::rgb_t                    sprite_color
);

  import video_pkg::*;

  logic                 sh_en;
  coord_x_t             sh_x;
  coord_y_t             sh_y;
  rgb_t                 sh_color;
  mask_row_t            mask_mem [SPRITE_SIZE];
  coord_x_t             dx;
  coord_y_t             dy;
  logic                 in_range;
  logic                 s1_valid;
  logic                 s1_in_range;
  logic [SPRITE_AW-1:0] s1_col;
  mask_row_t            s1_row;

  // shadow attributes load only on frame_start
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sh_en         <= 1'b0;
      sprites_ready <= 1'b0;
    end else begin
      sprites_ready <= frame_start;
      if (frame_start) sh_en <= sprite_en_in;
    end
  end

  always_ff @(posedge clk) begin
    if (frame_start) begin
      sh_x     <= sprite_x_in;
      sh_y     <= sprite_y_in;
      sh_color <= sprite_color_in;
    end
  end

  assign sprite_color = sh_color;

  // mask rows can be written at any time
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < SPRITE_SIZE; i++) mask_mem[i] <= '0;
    end else if (mask_we) begin
      mask_mem[mask_row] <= mask_data;
    end
  end

  // offsets wrap when pixel is left of / above the sprite, so check both bounds
  assign dx       = pixel_x - sh_x;
  assign dy       = pixel_y - sh_y;
  assign in_range = sh_en && (pixel_x >= sh_x) && (pixel_y >= sh_y)
                    && (dx < SPRITE_SIZE) && (dy < SPRITE_SIZE);

  // stage 1 does the range check and row read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid    <= 1'b0;
      s1_in_range <= 1'b0;
    end else begin
      s1_valid <= start_fetch;
      if (start_fetch) s1_in_range <= in_range;
    end
  end

  always_ff @(posedge clk) begin
    if (start_fetch) begin
      s1_col <= dx[SPRITE_AW-1:0];
      s1_row <= mask_mem[dy[SPRITE_AW-1:0]];
    end
  end

  // stage 2 selects the bit and holds the hit until the next fetch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_done <= 1'b0;
      sprite_hit <= 1'b0;
    end else begin
      fetch_done <= s1_valid;
      if (s1_valid) sprite_hit <= s1_in_range && s1_row[s1_col];
    end
  end

  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    start_fetch |=> (!start_fetch until fetch_done))
    else $error("sprite_fetcher: start_fetch while a fetch is in flight");

endmodule

/* design/pixel_composer.sv */
`timescale 1ns/1ps

module pixel_composer (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            bg_rdreq,
  input  video_pkg::rgb_t bg_pixel,
  input  logic            sprite_hit,
  input  video_pkg::rgb_t sprite_color,
  output video_pkg::rgb_t pix_out
);

  import video_pkg::*;

  rgb_t bg_hold;

  // bg fifo is show-ahead, so the head is valid in the pop cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bg_hold <= '0;
    end else if (bg_rdreq) begin
      bg_hold <= bg_pixel;
    end
  end

  // sprite is opaque where the mask bit is set
  assign pix_out = sprite_hit ? sprite_color : bg_hold;

endmodule

/* design/composer_ctrl.sv */
`timescale 1ns/1ps

module composer_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic bg_valid,       // bg fifo not empty
  input  logic fetch_done,
  input  logic new_frame,
  input  logic sprites_ready,
  input  logic last_pixel,
  input  logic wrfull,         // output fifo full
  output logic bg_rdreq,
  output logic start_fetch,
  output logic pc_enable,
  output logic wrreq
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_STABLE,
    S_SELECT,
    S_REQ_BG,
    S_WAIT_FETCH,
    S_COMPOSE
  } state_t;

  state_t state;
  state_t next;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state <= S_IDLE;
    else        state <= next;
  end

  always_comb begin
    bg_rdreq    = 1'b0;
    start_fetch = 1'b0;
    pc_enable   = 1'b0;
    wrreq       = 1'b0;
    next        = state;

    case (state)
      S_IDLE: begin
        if (new_frame || sprites_ready) next = S_STABLE;
      end

      S_STABLE: next = S_SELECT;   // coordinates settle

      S_SELECT: next = S_REQ_BG;

      S_REQ_BG: begin
        // pop only with room downstream, so the pixel never has to wait on two things
        if (bg_valid && !wrfull) begin
          bg_rdreq    = 1'b1;
          start_fetch = 1'b1;
          next        = S_WAIT_FETCH;
        end
      end

      S_WAIT_FETCH: begin
        if (fetch_done) next = S_COMPOSE;
      end

      S_COMPOSE: begin
        if (!wrfull) begin
          wrreq     = 1'b1;
          pc_enable = 1'b1;
          next      = last_pixel ? S_IDLE : S_STABLE;
        end
      end

      default: next = S_IDLE;
    endcase
  end

  a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n) wrreq |-> !wrfull)
    else $error("composer_ctrl: wrreq while output fifo full");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) bg_rdreq |-> bg_valid)
    else $error("composer_ctrl: bg_rdreq without bg_valid");

endmodule

/* design/frame_composer.sv */
`timescale 1ns/1ps

module frame_composer #(
  parameter int H_ACTIVE  = 640,
  parameter int V_ACTIVE  = 480,
  parameter int BG_DEPTH  = 16,
  parameter int OUT_DEPTH = 16
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            bg_push,
  input  video_pkg::rgb_t                 bg_data,
  output logic                            bg_full,
  input  logic                            frame_start,
  input  logic                            sprite_en_in,
  input  video_pkg::coord_x_t             sprite_x_in,
  input  video_pkg::coord_y_t             sprite_y_in,
  input  video_pkg::rgb_t                 sprite_color_in,
  input  logic                            mask_we,
  input  logic [video_pkg::SPRITE_AW-1:0] mask_row,
  input  video_pkg::mask_row_t            mask_data,
  input  logic                            out_pop,
  output video_pkg::rgb_t                 out_data,
  output logic                            out_empty
);

  import video_pkg::*;

  rgb_t     bg_head;
  logic     bg_empty;
  logic     bg_valid;
  logic     bg_rdreq;
  logic     start_fetch;
  logic     fetch_done;
  logic     sprites_ready;
  logic     sprite_hit;
  rgb_t     sprite_color;
  logic     pc_enable;
  coord_x_t pixel_x;
  coord_y_t pixel_y;
  logic     last_pixel;
  logic     new_frame;
  logic     wrreq;
  logic     wrfull;
  rgb_t     pix_out;

  assign bg_valid = !bg_empty;

  sync_fifo #(
    .payload_t(rgb_t),
    .DEPTH    (BG_DEPTH)
  ) bg_fifo (
    .clk    (clk),
    .rst_n  (rst_n),
    .push   (bg_push),
    .wr_data(bg_data),
    .pop    (bg_rdreq),
    .rd_data(bg_head),
    .full   (bg_full),
    .empty  (bg_empty)
  );

  pixel_counter #(
    .H_ACTIVE(H_ACTIVE),
    .V_ACTIVE(V_ACTIVE)
  ) u_pixel_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc_enable (pc_enable),
    .pixel_x   (pixel_x),
    .pixel_y   (pixel_y),
    .last_pixel(last_pixel),
    .new_frame (new_frame)
  );

  sprite_fetcher u_sprite_fetcher (
    .clk            (clk),
    .rst_n          (rst_n),
    .frame_start    (frame_start),
    .sprite_en_in   (sprite_en_in),
    .sprite_x_in    (sprite_x_in),
    .sprite_y_in    (sprite_y_in),
    .sprite_color_in(sprite_color_in),
    .mask_we        (mask_we),
    .mask_row       (mask_row),
    .mask_data      (mask_data),
    .start_fetch    (start_fetch),
    .pixel_x        (pixel_x),
    .pixel_y        (pixel_y),
    .sprites_ready  (sprites_ready),
    .fetch_done     (fetch_done),
    .sprite_hit     (sprite_hit),
    .sprite_color   (sprite_color)
  );

  pixel_composer u_pixel_composer (
    .clk         (clk),
    .rst_n       (rst_n),
    .bg_rdreq    (bg_rdreq),
    .bg_pixel    (bg_head),
    .sprite_hit  (sprite_hit),
    .sprite_color(sprite_color),
    .pix_out     (pix_out)
  );

  composer_ctrl u_composer_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .bg_valid     (bg_valid),
    .fetch_done   (fetch_done),
    .new_frame    (new_frame),
    .sprites_ready(sprites_ready),
    .last_pixel   (last_pixel),
    .wrfull       (wrfull),
    .bg_rdreq     (bg_rdreq),
    .start_fetch  (start_fetch),
    .pc_enable    (pc_enable),
    .wrreq        (wrreq)
  );

  sync_fifo #(
    .payload_t(rgb_t),
    .DEPTH    (OUT_DEPTH)
  ) out_fifo (
    .clk    (clk),
    .rst_n  (rst_n),
    .push   (wrreq),
    .wr_data(pix_out),
    .pop    (out_pop),
    .rd_data(out_data),
    .full   (wrfull),
    .empty  (out_empty)
  );

endmodule

/* sim/tb_frame_composer.sv */
`timescale 1ns/1ps

module tb_frame_composer;

  import video_pkg::*;

  localparam int H          = 16;
  localparam int V          = 12;
  localparam int FRAME_PIX  = H * V;
  localparam int WAIT_LIMIT = 2000;   // cycles per wait loop

  logic                 clk;
  logic                 rst_n;
  logic                 bg_push;
  rgb_t                 bg_data;
  logic                 bg_full;
  logic                 frame_start;
  logic                 sprite_en_in;
  coord_x_t             sprite_x_in;
  coord_y_t             sprite_y_in;
  rgb_t                 sprite_color_in;
  logic                 mask_we;
  logic [SPRITE_AW-1:0] mask_row;
  mask_row_t            mask_data;
  logic                 out_pop;
  rgb_t                 out_data;
  logic                 out_empty;

  // reference model of the mask, shadow attributes and pushed background
  mask_row_t mask_model [SPRITE_SIZE];
  logic      sp_en;
  int        sp_x;
  int        sp_y;
  rgb_t      sp_color;
  rgb_t      bg_q [$];
  int        pix_idx;     // raster position of the next expected output
  int        seed;
  int        errors;
  int        tests_run;
  int        tests_failed;
  bit        aborted;

  frame_composer #(
    .H_ACTIVE (H),
    .V_ACTIVE (V),
    .BG_DEPTH (8),
    .OUT_DEPTH(4)
  ) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // sprite colour on a mask hit and the background elsewhere
  function automatic rgb_t expected_pixel(int x, int y, rgb_t bg);
    int dx;
    int dy;
    dx = x - sp_x;
    dy = y - sp_y;
    if (sp_en && dx >= 0 && dx < SPRITE_SIZE && dy >= 0 && dy < SPRITE_SIZE
        && mask_model[dy][dx])
      return sp_color;
    return bg;
  endfunction

  task automatic drive_sprite_inputs(bit en, int x, int y, rgb_t color);
    @(posedge clk);
    sprite_en_in    <= en;
    sprite_x_in     <= coord_x_t'(x);
    sprite_y_in     <= coord_y_t'(y);
    sprite_color_in <= color;
  endtask

  task automatic pulse_frame_start(bit en, int x, int y, rgb_t color);
    drive_sprite_inputs(en, x, y, color);
    frame_start <= 1'b1;
    @(posedge clk);
    frame_start <= 1'b0;
    sp_en    = en;   // shadow copy taken on the strobe
    sp_x     = x;
    sp_y     = y;
    sp_color = color;
  endtask

  task automatic write_mask(int row, mask_row_t data);
    @(posedge clk);
    mask_we   <= 1'b1;
    mask_row  <= row[SPRITE_AW-1:0];
    mask_data <= data;
    @(posedge clk);
    mask_we <= 1'b0;
    mask_model[row] = data;
  endtask

  task automatic push_background(int n, int gap_max);
    int   waited;
    rgb_t val;
    for (int i = 0; i < n && !aborted; i++) begin
      repeat ($unsigned($random(seed)) % (gap_max + 1)) @(posedge clk);
      waited = 0;
      @(negedge clk);
      while (bg_full && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      if (bg_full) begin
        $display("background FIFO stayed full for %0d cycles", WAIT_LIMIT);
        errors++;
        aborted = 1'b1;
      end else begin
        val = rgb_t'($random(seed));
        @(posedge clk);
        bg_push <= 1'b1;
        bg_data <= val;
        bg_q.push_back(val);
        @(posedge clk);
        bg_push <= 1'b0;
      end
    end
  endtask

  // hold > 0 keeps out_pop low until the output FIFO has been busy that long
  task automatic drain_check(int n, int hold, int gap_max);
    int   waited;
    int   low_run;
    rgb_t bg;
    rgb_t exp;
    waited  = 0;
    low_run = 0;
    while (hold > 0 && low_run < hold && waited < WAIT_LIMIT) begin
      @(negedge clk);
      low_run = out_empty ? 0 : low_run + 1;
      waited++;
    end
    if (hold > 0 && low_run < hold) begin
      $display("output FIFO never stayed filled for %0d cycles", hold);
      errors++;
      aborted = 1'b1;
    end
    for (int i = 0; i < n && !aborted; i++) begin
      waited = 0;
      @(negedge clk);
      while (out_empty && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      if (out_empty) begin
        $display("no output pixel %0d within %0d cycles", pix_idx, WAIT_LIMIT);
        errors++;
        aborted = 1'b1;
      end else begin
        if (bg_q.size() == 0) begin
          $display("output pixel %0d appeared before its background was pushed", pix_idx);
          errors++;
        end else begin
          bg  = bg_q.pop_front();
          exp = expected_pixel(pix_idx % H, (pix_idx / H) % V, bg);
          if (out_data !== exp) begin
            $display("ERROR t=%0t out_data expected %h got %h at (%0d,%0d)", $time, exp,
                     out_data, pix_idx % H, (pix_idx / H) % V);
            errors++;
          end
        end
        pix_idx++;
        @(posedge clk);
        out_pop <= 1'b1;
        @(posedge clk);
        out_pop <= 1'b0;
        repeat ($unsigned($random(seed)) % (gap_max + 1)) @(posedge clk);
      end
    end
  endtask

  task automatic run_frame(int n_push, int push_gap, int hold, int pop_gap);
    fork
      push_background(n_push, push_gap);
      drain_check(FRAME_PIX, hold, pop_gap);
    join
  endtask

  task automatic expect_no_output(int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (out_empty !== 1'b1) begin
        $display("ERROR t=%0t out_empty expected 1 got %b", $time, out_empty);
        errors++;
        break;
      end
    end
  endtask

  task automatic report_test(string name, int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: fail, %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic test_reset_idle();
    int e0;
    e0 = errors;
    @(negedge clk);
    if (out_empty !== 1'b1) begin
      $display("ERROR t=%0t out_empty expected 1 got %b", $time, out_empty);
      errors++;
    end
    if (bg_full !== 1'b0) begin
      $display("ERROR t=%0t bg_full expected 0 got %b", $time, bg_full);
      errors++;
    end
    push_background(4, 0);   // these stay queued for the first frame
    expect_no_output(60);
    report_test("reset and idle", e0);
  endtask

  task automatic test_plain_frame();
    int e0;
    e0 = errors;
    for (int r = 0; r < SPRITE_SIZE; r++)
      write_mask(r, 8'hFF);   // full mask that the disabled sprite must not show
    pulse_frame_start(1'b0, 0, 0, 12'h000);
    run_frame(FRAME_PIX - 4, 0, 0, 0);
    report_test("sprite disabled frame", e0);
  endtask

  task automatic test_sprite_overlay();
    int e0;
    e0 = errors;
    for (int r = 0; r < SPRITE_SIZE; r++)
      write_mask(r, (r % 2) ? 8'hAA : 8'h55);   // checker
    pulse_frame_start(1'b1, 5, 3, 12'hF0F);
    run_frame(FRAME_PIX, 0, 0, 0);
    pulse_frame_start(1'b1, 12, 9, 12'h0FF);    // clipped at right and bottom
    run_frame(FRAME_PIX, 0, 0, 0);
    report_test("sprite overlay", e0);
  endtask

  task automatic test_back_pressure();
    int e0;
    e0 = errors;
    run_frame(FRAME_PIX, 0, 40, 5);
    expect_no_output(30);   // nothing duplicated
    report_test("output back-pressure", e0);
  endtask

  task automatic test_starvation();
    int e0;
    e0 = errors;
    run_frame(FRAME_PIX, 12, 0, 0);
    report_test("background starvation", e0);
  endtask

  task automatic test_continuous();
    int e0;
    e0 = errors;
    drive_sprite_inputs(1'b1, 0, 0, 12'h123);   // no strobe so the model keeps the old sprite
    run_frame(FRAME_PIX, 0, 0, 0);
    pulse_frame_start(1'b1, 0, 0, 12'h123);
    run_frame(FRAME_PIX, 0, 0, 0);
    report_test("continuous frames", e0);
  endtask

  initial begin
    seed            = 32'h65ec0fa9;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    aborted         = 1'b0;
    pix_idx         = 0;
    sp_en           = 1'b0;
    sp_x            = 0;
    sp_y            = 0;
    sp_color        = '0;
    for (int i = 0; i < SPRITE_SIZE; i++) mask_model[i] = '0;
    rst_n           = 1'b0;
    bg_push         = 1'b0;
    bg_data         = '0;
    frame_start     = 1'b0;
    sprite_en_in    = 1'b0;
    sprite_x_in     = '0;
    sprite_y_in     = '0;
    sprite_color_in = '0;
    mask_we         = 1'b0;
    mask_row        = '0;
    mask_data       = '0;
    out_pop         = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_idle();
    test_plain_frame();
    test_sprite_overlay();
    test_back_pressure();
    test_starvation();
    test_continuous();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* frame_composer.f */
design/video_pkg.sv
design/sync_fifo.sv
design/pixel_counter.sv
design/sprite_fetcher.sv
design/pixel_composer.sv
design/composer_ctrl.sv
design/frame_composer.sv
sim/tb_frame_composer.sv

/* Bender.yml */
package:
  name: frame_composer

sources:
  - design/video_pkg.sv
  - design/sync_fifo.sv
  - design/pixel_counter.sv
  - design/sprite_fetcher.sv
  - design/pixel_composer.sv
  - design/composer_ctrl.sv
  - design/frame_composer.sv
  - target: simulation
    files:
      - sim/tb_frame_composer.sv
